//--- uartPkg.sv
// uart package
// frame constants and the byte and receive-entry types shared by the uart blocks
`default_nettype none

package uartPkg;

	////////////////////
	// frame format
	////////////////////

	localparam int dataBits = 8;	// data bits per frame
	localparam int ovsTicks = 16;	// oversampling ticks per bit
	localparam int sbTick = 16;		// ticks in the stop bit, one stop bit

	////////////////////
	// payload types
	////////////////////

	// one data byte on the line
	typedef logic [dataBits-1:0] uartByte_t;

	// receive fifo entry
	// byte plus framing error, 9 bits
	typedef struct packed
	{
		uartByte_t data;	// received byte
		logic frameErr;		// stop bit was low
	} rxEntry_t;

endpackage

`default_nettype wire

//--- baudGen.sv
// baud generator
// free-running divider, one-cycle sTick every clkDivisor clocks
`timescale 1ns/10ps
`default_nettype none

module baudGen #(
	parameter int clkDivisor = 27	// clocks per oversampling tick
) (
	input wire logic clk,
	input wire logic reset,
	output logic sTick	// 16x bit-rate pulse
);

	localparam int cntW = (clkDivisor > 1) ? $clog2(clkDivisor) : 1;

	logic [cntW-1:0] cnt;	// divider count

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			cnt <= '0;
			sTick <= 1'b0;
		end
		else
		begin
			// wrap at divisor-1
			if (cnt == cntW'(clkDivisor - 1))
				cnt <= '0;
			else
				cnt <= cnt + 1'b1;
			sTick <= (cnt == cntW'(clkDivisor - 1));	// pulse on the wrap
		end
	end

	// tick is a single-cycle pulse
	assert property (@(posedge clk) disable iff (reset)
		(clkDivisor > 1 && sTick) |=> !sTick);

endmodule

`default_nettype wire

//--- uartFifo.sv
// uart fifo
// first-word-fall-through buffer, any payload type, sticky overflow flag
`timescale 1ns/10ps
`default_nettype none

module uartFifo #(
	parameter type payload_t = logic [7:0],	// entry type
	parameter int fifoDepth = 16			// entries, power of two
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic push,
	input wire payload_t pushData,
	input wire logic pop,
	output payload_t popData,	// head, valid while !empty
	output logic empty,
	output logic full,
	output logic overflow		// push lost while full, sticky
);

	localparam int ptrW = $clog2(fifoDepth);

	payload_t mem [fifoDepth];	// storage, no reset
	logic [ptrW-1:0] wrPtr;
	logic [ptrW-1:0] rdPtr;
	logic [ptrW:0] count;		// occupancy 0..fifoDepth
	logic [ptrW:0] countNext;
	logic doPush;
	logic doPop;

	////////////////////
	// accept rules
	////////////////////

	assign doPop = pop && !empty;				// pop on empty ignored
	assign doPush = push && (!full || doPop);	// full but popping frees a slot
	assign countNext = count + doPush - doPop;

	// head shows through
	assign popData = mem[rdPtr];

	always_ff @(posedge clk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	////////////////////
	// pointers, levels
	////////////////////

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			empty <= 1'b1;
			full <= 1'b0;
			overflow <= 1'b0;
		end
		else
		begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;	// wraps, depth is 2^n
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			count <= countNext;
			empty <= (countNext == '0);					// registered levels
			full <= (countNext == (ptrW+1)'(fifoDepth));
			if (push && !doPush)
				overflow <= 1'b1;	// cleared by reset only
		end
	end

	// occupancy bounded
	assert property (@(posedge clk) disable iff (reset)
		count <= (ptrW+1)'(fifoDepth));

endmodule

`default_nettype wire

//--- uartTrans.sv
// uart transmitter
// pops the transmit fifo and shifts out 8N1 frames on the 16x tick
`timescale 1ns/10ps
`default_nettype none

module uartTrans import uartPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic sTick,		// oversampling tick
	input wire logic fifoEmpty,	// transmit fifo level
	input wire uartByte_t din,	// fifo head
	output logic txPop,			// one-cycle fifo pop
	output logic tx				// serial out, registered
);

	localparam int sW = $clog2((ovsTicks > sbTick) ? ovsTicks : sbTick);
	localparam int nW = $clog2(dataBits);

	typedef enum logic [1:0] {idle, start, data, stop} txState_t;

	txState_t stateReg, stateNext;
	logic [sW-1:0] sReg, sNext;	// tick count within a bit
	logic [nW-1:0] nReg, nNext;	// data bit index
	uartByte_t bReg, bNext;		// shift register
	logic txNext;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
			tx <= 1'b1;	// line idles high
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
			tx <= txNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;	// payload only

	////////////////////
	// frame FSM
	////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		txPop = 1'b0;

		case (stateReg)
			idle:
			begin
				if (!fifoEmpty)
				begin
					txPop = 1'b1;	// take the head
					bNext = din;
					sNext = '0;
					stateNext = start;
				end
			end
			start:
			begin
				if (sTick)
				begin
					if (sReg == sW'(ovsTicks - 1))
					begin
						sNext = '0;
						nNext = '0;
						stateNext = data;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				if (sTick)
				begin
					if (sReg == sW'(ovsTicks - 1))
					begin
						sNext = '0;
						bNext = bReg >> 1;	// next bit to lsb
						if (nReg == nW'(dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default:	// stop
			begin
				if (sTick)
				begin
					if (sReg == sW'(sbTick - 1))
						stateNext = idle;	// may pop again right away
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	// line level follows the next state so tx moves with the state register
	always_comb
	begin
		case (stateNext)
			start: txNext = 1'b0;
			data: txNext = bNext[0];	// lsb first
			default: txNext = 1'b1;
		endcase
	end

	// pop only from idle, start bit on the following edge
	assert property (@(posedge clk) disable iff (reset)
		txPop |-> (stateReg == idle) ##1 (stateReg == start && !tx));
	assert property (@(posedge clk) disable iff (reset) txPop |-> !fifoEmpty);
	assert property (@(posedge clk) disable iff (reset) (stateReg == idle) |-> tx);

endmodule

`default_nettype wire

//--- uartRecv.sv
// uart receiver
// 16x oversampled 8N1 receiver, mid-bit sampling, stop-bit framing check
`timescale 1ns/10ps
`default_nettype none

module uartRecv import uartPkg::*; (
	input wire logic clk,
	input wire logic reset,
	input wire logic sTick,		// oversampling tick
	input wire logic rx,		// serial in, asynchronous
	output logic rxDoneTick,	// one-cycle push strobe
	output rxEntry_t rxEntry	// valid with rxDoneTick
);

	localparam int sW = $clog2((ovsTicks > sbTick) ? ovsTicks : sbTick);
	localparam int nW = $clog2(dataBits);

	typedef enum logic [1:0] {idle, start, data, stop} rxState_t;

	rxState_t stateReg, stateNext;
	logic [sW-1:0] sReg, sNext;	// tick count
	logic [nW-1:0] nReg, nNext;	// bits received
	uartByte_t bReg, bNext;		// shift in, msb side
	logic rxMeta;				// first sync flop
	logic rxSync;				// synchronized line

	// two-flop synchronizer, idle level high
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end
		else
		begin
			rxMeta <= rx;
			rxSync <= rxMeta;
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			stateReg <= idle;
			sReg <= '0;
			nReg <= '0;
		end
		else
		begin
			stateReg <= stateNext;
			sReg <= sNext;
			nReg <= nNext;
		end
	end

	always_ff @(posedge clk)
		bReg <= bNext;

	////////////////////
	// receive FSM
	////////////////////

	always_comb
	begin
		stateNext = stateReg;
		sNext = sReg;
		nNext = nReg;
		bNext = bReg;
		rxDoneTick = 1'b0;

		case (stateReg)
			idle:
			begin
				if (!rxSync)	// possible start edge
				begin
					sNext = '0;
					stateNext = start;
				end
			end
			start:
			begin
				if (sTick)
				begin
					if (sReg == sW'(ovsTicks/2 - 1))	// middle of start bit
					begin
						sNext = '0;
						nNext = '0;
						stateNext = rxSync ? idle : data;	// high again means glitch
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			data:
			begin
				if (sTick)
				begin
					if (sReg == sW'(ovsTicks - 1))
					begin
						sNext = '0;
						bNext = {rxSync, bReg[dataBits-1:1]};	// lsb arrives first
						if (nReg == nW'(dataBits - 1))
							stateNext = stop;
						else
							nNext = nReg + 1'b1;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
			default:	// stop
			begin
				if (sTick)
				begin
					if (sReg == sW'(sbTick - 1))
					begin
						rxDoneTick = 1'b1;	// stop sample, entry valid now
						stateNext = idle;
					end
					else
						sNext = sReg + 1'b1;
				end
			end
		endcase
	end

	// low stop bit is a framing error
	assign rxEntry = '{data: bReg, frameErr: !rxSync};

	// one push per frame
	assert property (@(posedge clk) disable iff (reset) rxDoneTick |=> !rxDoneTick);

endmodule

`default_nettype wire

//--- uartPeripheral.sv
// uart peripheral top
// baud generator, tx and rx fifos, transmitter and receiver behind strobe/level ports
`timescale 1ns/10ps
`default_nettype none

module uartPeripheral import uartPkg::*; #(
	parameter int clkDivisor = 27,	// clocks per 16x tick
	parameter int fifoDepth = 16	// entries per fifo
) (
	input wire logic clk,
	input wire logic reset,
	input wire logic wrEn,			// uart write strobe
	input wire uartByte_t wrData,
	input wire logic rdEn,			// uart read strobe, pops rx head
	output uartByte_t rdData,		// rx head byte
	output logic rdFrameErr,		// rx head framing error
	output logic txFull,
	output logic txEmpty,
	output logic rxEmpty,
	output logic txOverrun,			// write lost, sticky
	output logic rxOverrun,			// frame lost, sticky
	output logic tx,
	input wire logic rx
);

	logic sTick;			// 16x tick
	uartByte_t txHead;		// tx fifo head to transmitter
	logic txPop;
	logic rxDoneTick;		// rx fifo push
	rxEntry_t rxEntry;
	rxEntry_t rxHead;

	baudGen #(.clkDivisor(clkDivisor)) baudGenI (
		.clk(clk), .reset(reset), .sTick(sTick)
	);

	////////////////////
	// transmit path
	////////////////////

	uartFifo #(.payload_t(uartByte_t), .fifoDepth(fifoDepth)) txFifo (
		.clk(clk), .reset(reset),
		.push(wrEn), .pushData(wrData),
		.pop(txPop), .popData(txHead),
		.empty(txEmpty), .full(txFull), .overflow(txOverrun)
	);

	uartTrans uartTransI (
		.clk(clk), .reset(reset), .sTick(sTick),
		.fifoEmpty(txEmpty), .din(txHead), .txPop(txPop), .tx(tx)
	);

	////////////////////
	// receive path
	////////////////////

	uartRecv uartRecvI (
		.clk(clk), .reset(reset), .sTick(sTick), .rx(rx),
		.rxDoneTick(rxDoneTick), .rxEntry(rxEntry)
	);

	// receiver never stalls, a full fifo just drops and flags
	uartFifo #(.payload_t(rxEntry_t), .fifoDepth(fifoDepth)) rxFifo (
		.clk(clk), .reset(reset),
		.push(rxDoneTick), .pushData(rxEntry),
		.pop(rdEn), .popData(rxHead),
		.empty(rxEmpty), .full(), .overflow(rxOverrun)
	);

	assign rdData = rxHead.data;
	assign rdFrameErr = rxHead.frameErr;

endmodule

`default_nettype wire

//--- uartPeripheral_tb.sv
// uart peripheral testbench
// loopback and serial-driver stimulus against a queue model, status rules as assertions
`timescale 1ns/10ps
`default_nettype none

module uartPeripheral_tb import uartPkg::*; ();

	localparam int clkDiv = 2;
	localparam int depth = 16;
	localparam int bitCycles = ovsTicks * clkDiv;				// 32 clocks per bit
	localparam int frameCycles = (dataBits + 2) * bitCycles;	// 320 clocks per 8N1 frame
	localparam int runLimit = 60 * frameCycles + 2000;			// whole run plus margin
	localparam int waitLimit = 3 * frameCycles;					// one handshake wait

	logic clk;
	logic reset;
	logic wrEn;
	uartByte_t wrData;
	logic rdEn;
	uartByte_t rdData;
	logic rdFrameErr;
	logic txFull;
	logic txEmpty;
	logic rxEmpty;
	logic txOverrun;
	logic rxOverrun;
	logic tx;
	logic rxLine;	// into the dut rx pin
	logic drvLine;	// serial driver output
	logic loopback;	// rx follows tx

	uartByte_t expQ[$];	// expected receive order
	string curTest;
	int testErrs;
	int testsRun;
	int testsFailed;
	int checksFailed;
	int cycles;

	assign rxLine = loopback ? tx : drvLine;

	uartPeripheral #(.clkDivisor(clkDiv), .fifoDepth(depth)) uut (
		.clk(clk), .reset(reset),
		.wrEn(wrEn), .wrData(wrData),
		.rdEn(rdEn), .rdData(rdData), .rdFrameErr(rdFrameErr),
		.txFull(txFull), .txEmpty(txEmpty), .rxEmpty(rxEmpty),
		.txOverrun(txOverrun), .rxOverrun(rxOverrun),
		.tx(tx), .rx(rxLine)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns
	end

	// run limit
	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= runLimit)
		begin
			$display("timeout: run went past %0d cycles", runLimit);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	////////////////////
	// status rules
	////////////////////

	assert property (@(posedge clk) disable iff (reset) !(txFull && txEmpty))
	else
	begin
		$display("%s: txFull and txEmpty are high together", curTest);
		testErrs++;
	end

	assert property (@(posedge clk) disable iff (reset) txOverrun |=> txOverrun)
	else
	begin
		$display("%s: txOverrun cleared without reset", curTest);
		testErrs++;
	end

	assert property (@(posedge clk) disable iff (reset) rxOverrun |=> rxOverrun)
	else
	begin
		$display("%s: rxOverrun cleared without reset", curTest);
		testErrs++;
	end

	// a write is lost only into a full fifo
	assert property (@(posedge clk) disable iff (reset) $rose(txOverrun) |-> $past(txFull))
	else
	begin
		$display("%s: txOverrun set while the tx fifo was not full", curTest);
		testErrs++;
	end

	////////////////////
	// helpers
	////////////////////

	task automatic checkVal(input string what, input int expVal, input int actVal);
		assert (actVal == expVal)
		else
		begin
			$display("ERR %s %s expected %0h actual %0h", curTest, what, expVal, actVal);
			testErrs++;
		end
	endtask

	task automatic startTest(input string name);
		curTest = name;
		testErrs = 0;
	endtask

	task automatic endTest();
		testsRun++;
		checksFailed += testErrs;
		if (testErrs == 0)
			$display("ok   %s", curTest);
		else
		begin
			$display("fail %s, %0d check(s) wrong", curTest, testErrs);
			testsFailed++;
		end
		testErrs = 0;
	endtask

	// called on a falling edge, returns on the next one
	task automatic writeByte(input uartByte_t b);
		wrData = b;
		wrEn = 1'b1;
		@(negedge clk);
		wrEn = 1'b0;
	endtask

	task automatic waitTxLow(output bit seen);
		int n;
		n = 0;
		while (tx && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		seen = !tx;
		if (!seen)
		begin
			$display("%s: tx never fell for a start bit", curTest);
			testErrs++;
		end
	endtask

	// wait for the rx head, compare, pop it
	task automatic readEntry(input uartByte_t expByte, input logic expErr);
		int n;
		n = 0;
		while (rxEmpty && n < waitLimit)
		begin
			@(negedge clk);
			n++;
		end
		if (rxEmpty)
		begin
			$display("%s: no entry reached the rx fifo in %0d cycles", curTest, waitLimit);
			testErrs++;
		end
		else
		begin
			checkVal("rdData", expByte, rdData);
			checkVal("rdFrameErr", expErr, rdFrameErr);
			rdEn = 1'b1;	// one-cycle pop
			@(negedge clk);
			rdEn = 1'b0;
		end
	endtask

	// serial driver, one 8N1 frame then an idle bit
	task automatic sendFrame(input uartByte_t b, input logic stopLevel);
		int i;
		drvLine = 1'b0;	// start
		repeat (bitCycles) @(negedge clk);
		for (i = 0; i < dataBits; i++)
		begin
			drvLine = b[i];	// lsb first
			repeat (bitCycles) @(negedge clk);
		end
		drvLine = stopLevel;
		// low stop is cut short, line is high again before the receiver's restart check
		repeat (stopLevel ? bitCycles : bitCycles * 3 / 4) @(negedge clk);
		drvLine = 1'b1;
		repeat (stopLevel ? bitCycles : bitCycles + bitCycles / 4) @(negedge clk);
	endtask

	////////////////////
	// stimulus
	////////////////////

	initial
	begin
		uartByte_t b;
		bit seen;
		int i;

		void'($urandom(34));
		reset = 1'b1;
		wrEn = 1'b0;
		wrData = '0;
		rdEn = 1'b0;
		drvLine = 1'b1;
		loopback = 1'b0;
		repeat (5) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		startTest("resetState");
		checkVal("tx", 1, tx);
		checkVal("txEmpty", 1, txEmpty);
		checkVal("rxEmpty", 1, rxEmpty);
		checkVal("txFull", 0, txFull);
		checkVal("txOverrun", 0, txOverrun);
		checkVal("rxOverrun", 0, rxOverrun);
		endTest();

		startTest("frameFormat");
		b = uartByte_t'($urandom());
		writeByte(b);
		waitTxLow(seen);
		if (seen)
		begin
			checkVal("txEmpty after pop", 1, txEmpty);
			repeat (bitCycles / 2) @(negedge clk);	// middle of start bit
			checkVal("start bit", 0, tx);
			for (i = 0; i < dataBits; i++)
			begin
				repeat (bitCycles) @(negedge clk);
				checkVal($sformatf("data bit %0d", i), b[i], tx);
			end
			repeat (bitCycles) @(negedge clk);
			checkVal("stop bit", 1, tx);
			repeat (bitCycles) @(negedge clk);	// let the stop bit finish
		end
		endTest();

		startTest("loopbackOrder");
		loopback = 1'b1;
		for (i = 0; i < 8; i++)
		begin
			b = uartByte_t'($urandom());
			expQ.push_back(b);
			writeByte(b);	// 8 entries, well under depth
		end
		while (expQ.size() > 0)
			readEntry(expQ.pop_front(), 1'b0);
		endTest();

		startTest("framingError");
		repeat (2 * bitCycles) @(negedge clk);	// loopback frames all done
		loopback = 1'b0;
		b = uartByte_t'($urandom());
		sendFrame(b, 1'b0);
		readEntry(b, 1'b1);
		b = uartByte_t'($urandom());
		sendFrame(b, 1'b1);	// good frame after the bad one
		readEntry(b, 1'b0);
		endTest();

		startTest("rxOverrun");
		checkVal("rxOverrun before", 0, rxOverrun);
		for (i = 0; i < depth + 1; i++)
		begin
			b = uartByte_t'($urandom());
			if (expQ.size() < depth)
				expQ.push_back(b);	// model fifo full, last one dropped
			sendFrame(b, 1'b1);
		end
		checkVal("rxOverrun", 1, rxOverrun);
		while (expQ.size() > 0)
			readEntry(expQ.pop_front(), 1'b0);
		checkVal("rxEmpty after drain", 1, rxEmpty);
		endTest();

		startTest("txOverflow");
		loopback = 1'b1;
		for (i = 0; i < depth + 2; i++)
		begin
			b = uartByte_t'($urandom());
			wrData = b;
			wrEn = 1'b1;
			if (i < depth + 1)
				expQ.push_back(b);	// one in the transmitter, depth in the fifo
			@(negedge clk);
		end
		wrEn = 1'b0;
		checkVal("txFull", 1, txFull);
		checkVal("txOverrun", 1, txOverrun);
		while (expQ.size() > 0)
			readEntry(expQ.pop_front(), 1'b0);
		repeat (2 * frameCycles) @(negedge clk);	// nothing more may arrive
		checkVal("rxEmpty at end", 1, rxEmpty);
		checkVal("txEmpty at end", 1, txEmpty);
		endTest();

		$display("tests run %0d, tests failed %0d, wrong checks %0d",
			testsRun, testsFailed, checksFailed);
		if (testsFailed == 0 && testErrs == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- uartPeripheral.f
uartPkg.sv
baudGen.sv
uartFifo.sv
uartTrans.sv
uartRecv.sv
uartPeripheral.sv
uartPeripheral_tb.sv

//--- Bender.yml
package:
  name: uartPeripheral

sources:
  - uartPkg.sv
  - baudGen.sv
  - uartFifo.sv
  - uartTrans.sv
  - uartRecv.sv
  - uartPeripheral.sv
  - target: test
    files:
      - uartPeripheral_tb.sv
